// ==== btbGeometryPkg.sv ====
`default_nettype none

// **************************************************
// Fetch address geometry of the banked BTB.
// **************************************************
package btbGeometryPkg;

	// Width of a program counter.
	localparam int SIZE_PC = 32;
	// Byte offset bits below every instruction.
	localparam int INST_BYTE_OFFSET = 3;
	// Instruction address once the byte offset is gone.
	localparam int INST_ADDR_BITS = SIZE_PC - INST_BYTE_OFFSET;

	// Lanes per lookup, one bank per lane.
	localparam int FETCH_WIDTH = 4;
	localparam int FETCH_WIDTH_LOG = 2;

	// Total entries, spread evenly over the banks.
	localparam int BTB_SIZE_LOG = 8;
	localparam int BTB_SIZE = 1 << BTB_SIZE_LOG;
	localparam int BANK_DEPTH = BTB_SIZE / FETCH_WIDTH;
	localparam int INDEX_BITS = BTB_SIZE_LOG - FETCH_WIDTH_LOG;

	// Everything above bank and index is tag.
	localparam int TAG_BITS = SIZE_PC - BTB_SIZE_LOG - INST_BYTE_OFFSET;

	typedef logic [SIZE_PC-1:0] pcT;
	typedef logic [TAG_BITS-1:0] tagT;
	typedef logic [INDEX_BITS-1:0] indexT;
	typedef logic [FETCH_WIDTH_LOG-1:0] laneT;

endpackage

`default_nettype wire

// ==== btbEntryPkg.sv ====
`default_nettype none

// **************************************************
// Contents of one BTB entry.
// **************************************************
package btbEntryPkg;

	// Width of the control type field.
	localparam int CTRL_TYPE_BITS = 2;

	// Conditional, jump, call or return.
	// The code itself is opaque to the BTB.
	typedef logic [CTRL_TYPE_BITS-1:0] ctrlTypeT;

	// A taken target is a full PC.
	typedef btbGeometryPkg::pcT targetT;

endpackage

`default_nettype wire

// ==== btbIf.sv ====
`timescale 1ns/10ps
`default_nettype none

// **************************************************
// Bank read bus, one element per bank.
// **************************************************
interface btbReadIf;

	// Index presented to each bank.
	btbGeometryPkg::indexT rdAddr [btbGeometryPkg::FETCH_WIDTH];

	// Entry seen at that index.
	logic rdValid [btbGeometryPkg::FETCH_WIDTH];
	btbGeometryPkg::tagT rdTag [btbGeometryPkg::FETCH_WIDTH];
	btbEntryPkg::targetT rdTarget [btbGeometryPkg::FETCH_WIDTH];
	btbEntryPkg::ctrlTypeT rdCtrlType [btbGeometryPkg::FETCH_WIDTH];

	// Address generation side.
	modport lane (output rdAddr);

	// A bank drives only its own element.
	modport bank (input rdAddr, output rdValid, output rdTag,
		output rdTarget, output rdCtrlType);

	// Hit logic side.
	modport check (input rdValid, input rdTag, input rdTarget, input rdCtrlType);

endinterface

// **************************************************
// Bank write bus, shared by all banks.
// **************************************************
interface btbWriteIf;

	// One-hot bank write enable.
	logic [btbGeometryPkg::FETCH_WIDTH-1:0] bankWe;
	btbGeometryPkg::indexT wrAddr;
	btbGeometryPkg::tagT wrTag;
	btbEntryPkg::targetT wrTarget;
	btbEntryPkg::ctrlTypeT wrCtrlType;

	modport source (output bankWe, output wrAddr, output wrTag,
		output wrTarget, output wrCtrlType);
	modport sink (input bankWe, input wrAddr, input wrTag,
		input wrTarget, input wrCtrlType);

endinterface

`default_nettype wire

// ==== btbLaneAddr.sv ====
`timescale 1ns/10ps
`default_nettype none

// Lookup address generation for the four fetch lanes.
module btbLaneAddr (
	input  btbGeometryPkg::pcT pc_i,
	btbReadIf.lane rd,
	output btbGeometryPkg::tagT [btbGeometryPkg::FETCH_WIDTH-1:0] instTag_o,
	output btbGeometryPkg::laneT startBank_o
);

	// Instruction address of the first slot.
	logic [btbGeometryPkg::INST_ADDR_BITS-1:0] instBase;

	// Instruction address of every lane.
	logic [btbGeometryPkg::INST_ADDR_BITS-1:0] laneInstAddr [btbGeometryPkg::FETCH_WIDTH];

	// Bank index wanted by every lane.
	btbGeometryPkg::indexT laneIndex [btbGeometryPkg::FETCH_WIDTH];

	// Drop the byte offset.
	assign instBase = pc_i[btbGeometryPkg::SIZE_PC-1:btbGeometryPkg::INST_BYTE_OFFSET];

	// **************************************************
	// Per-lane address split.
	// **************************************************
	always_comb
	begin
		for (int i = 0; i < btbGeometryPkg::FETCH_WIDTH; i++)
		begin
			// Slot i of the block; the carry may ripple into the tag.
			laneInstAddr[i] = instBase + btbGeometryPkg::INST_ADDR_BITS'(i);

			// Tag sits above bank and index.
			instTag_o[i] = laneInstAddr[i][btbGeometryPkg::BTB_SIZE_LOG +:
				btbGeometryPkg::TAG_BITS];

			// Index sits just above the bank bits.
			laneIndex[i] = laneInstAddr[i][btbGeometryPkg::FETCH_WIDTH_LOG +:
				btbGeometryPkg::INDEX_BITS];
		end
	end

	// Bank of lane 0.
	// The remaining lanes follow it in order, mod 4.
	assign startBank_o = laneInstAddr[0][btbGeometryPkg::FETCH_WIDTH_LOG-1:0];

	// **************************************************
	// Index rotation onto the banks.
	// **************************************************
	always_comb
	begin
		btbGeometryPkg::laneT laneSel;

		laneSel = '0;
		for (int b = 0; b < btbGeometryPkg::FETCH_WIDTH; b++)
		begin
			// Lane i lands in bank (startBank + i) mod 4.
			// So bank b serves lane (b - startBank) mod 4.
			laneSel = btbGeometryPkg::laneT'(b - startBank_o);
			rd.rdAddr[b] = laneIndex[laneSel];
		end
	end

endmodule

`default_nettype wire

// ==== btbBank.sv ====
`timescale 1ns/10ps
`default_nettype none

// One BTB bank with asynchronous read and synchronous write.
module btbBank #(
	parameter int BANK_ID = 0
) (
	input  logic clk,
	input  logic rst_i,
	btbReadIf.bank rd,
	btbWriteIf.sink wr
);

	// Valid bit per entry.
	logic [btbGeometryPkg::BANK_DEPTH-1:0] validQ;

	// Entry payload.
	btbGeometryPkg::tagT tagMem [btbGeometryPkg::BANK_DEPTH];
	btbEntryPkg::targetT targetMem [btbGeometryPkg::BANK_DEPTH];
	btbEntryPkg::ctrlTypeT ctrlTypeMem [btbGeometryPkg::BANK_DEPTH];

	// **************************************************
	// Write port.
	// **************************************************
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			// Empty the whole bank.
			validQ <= '0;
		end
		else if (wr.bankWe[BANK_ID])
		begin
			validQ[wr.wrAddr] <= 1'b1;
		end
	end

	// Payload write, same strobe as the valid bit.
	always_ff @(posedge clk)
	begin
		if (wr.bankWe[BANK_ID])
		begin
			tagMem[wr.wrAddr] <= wr.wrTag;
			targetMem[wr.wrAddr] <= wr.wrTarget;
			ctrlTypeMem[wr.wrAddr] <= wr.wrCtrlType;
		end
	end

	// Read port, this bank's slice only.
	// A write shows up here right after the edge.
	assign rd.rdValid[BANK_ID] = validQ[rd.rdAddr[BANK_ID]];
	assign rd.rdTag[BANK_ID] = tagMem[rd.rdAddr[BANK_ID]];
	assign rd.rdTarget[BANK_ID] = targetMem[rd.rdAddr[BANK_ID]];
	assign rd.rdCtrlType[BANK_ID] = ctrlTypeMem[rd.rdAddr[BANK_ID]];

endmodule

`default_nettype wire

// ==== btbUpdate.sv ====
`timescale 1ns/10ps
`default_nettype none

// Turns a single update into a one-bank write.
module btbUpdate (
	input  logic updateEn_i,
	input  btbGeometryPkg::pcT updatePc_i,
	input  btbEntryPkg::targetT updateTarget_i,
	input  btbEntryPkg::ctrlTypeT updateCtrlType_i,
	btbWriteIf.source wr
);

	// Instruction address of the updated branch.
	logic [btbGeometryPkg::INST_ADDR_BITS-1:0] updateInstAddr;

	// Bank that owns this slot.
	btbGeometryPkg::laneT updateBank;

	assign updateInstAddr = updatePc_i[btbGeometryPkg::SIZE_PC-1:btbGeometryPkg::INST_BYTE_OFFSET];

	// Same mapping as the lookup side.
	assign updateBank = updateInstAddr[btbGeometryPkg::FETCH_WIDTH_LOG-1:0];
	assign wr.wrAddr = updateInstAddr[btbGeometryPkg::FETCH_WIDTH_LOG +:
		btbGeometryPkg::INDEX_BITS];
	assign wr.wrTag = updateInstAddr[btbGeometryPkg::BTB_SIZE_LOG +:
		btbGeometryPkg::TAG_BITS];

	// Payload goes out unchanged.
	assign wr.wrTarget = updateTarget_i;
	assign wr.wrCtrlType = updateCtrlType_i;

	// **************************************************
	// Bank write enables.
	// **************************************************
	always_comb
	begin
		for (int b = 0; b < btbGeometryPkg::FETCH_WIDTH; b++)
		begin
			// At most one bit set, and only with the strobe.
			wr.bankWe[b] = updateEn_i && (updateBank == btbGeometryPkg::laneT'(b));
		end
	end

endmodule

`default_nettype wire

// ==== btbHitCheck.sv ====
`timescale 1ns/10ps
`default_nettype none

// Puts bank data back into lane order and forms the lane results.
module btbHitCheck (
	btbReadIf.check rd,
	input  btbGeometryPkg::tagT [btbGeometryPkg::FETCH_WIDTH-1:0] instTag_i,
	input  btbGeometryPkg::laneT startBank_i,
	output logic [btbGeometryPkg::FETCH_WIDTH-1:0] laneHit_o,
	output btbEntryPkg::targetT [btbGeometryPkg::FETCH_WIDTH-1:0] laneTarget_o,
	output btbEntryPkg::ctrlTypeT [btbGeometryPkg::FETCH_WIDTH-1:0] laneCtrlType_o
);

	// Valid and tag in lane order.
	logic laneValid [btbGeometryPkg::FETCH_WIDTH];
	btbGeometryPkg::tagT laneTag [btbGeometryPkg::FETCH_WIDTH];

	// **************************************************
	// Data rotation back to lane order.
	// **************************************************
	always_comb
	begin
		btbGeometryPkg::laneT bankSel;

		bankSel = '0;
		for (int i = 0; i < btbGeometryPkg::FETCH_WIDTH; i++)
		begin
			// Lane i reads bank (startBank + i) mod 4.
			bankSel = btbGeometryPkg::laneT'(startBank_i + i);
			laneValid[i] = rd.rdValid[bankSel];
			laneTag[i] = rd.rdTag[bankSel];

			// Target and type pass through, hit or not.
			laneTarget_o[i] = rd.rdTarget[bankSel];
			laneCtrlType_o[i] = rd.rdCtrlType[bankSel];
		end
	end

	// **************************************************
	// Hit detection.
	// **************************************************
	always_comb
	begin
		for (int i = 0; i < btbGeometryPkg::FETCH_WIDTH; i++)
		begin
			// Valid entry with a matching tag.
			laneHit_o[i] = laneValid[i] & (laneTag[i] == instTag_i[i]);
		end
	end

endmodule

`default_nettype wire

// ==== btbTop.sv ====
`timescale 1ns/10ps
`default_nettype none

// Banked branch target buffer for a 4-wide fetch stage.
module btbTop (
	input  logic clk,
	input  logic rst_i,

	// Fetch block lookup.
	input  btbGeometryPkg::pcT pc_i,

	// Updates from the branch-order side.
	input  logic updateEn_i,
	input  btbGeometryPkg::pcT updatePc_i,
	input  btbEntryPkg::targetT updateTarget_i,
	input  btbEntryPkg::ctrlTypeT updateCtrlType_i,

	// Per-lane prediction.
	output logic [btbGeometryPkg::FETCH_WIDTH-1:0] laneHit_o,
	output btbEntryPkg::targetT [btbGeometryPkg::FETCH_WIDTH-1:0] laneTarget_o,
	output btbEntryPkg::ctrlTypeT [btbGeometryPkg::FETCH_WIDTH-1:0] laneCtrlType_o
);

	// Per-lane tag for the compare.
	btbGeometryPkg::tagT [btbGeometryPkg::FETCH_WIDTH-1:0] instTag;
	// Bank of lane 0.
	btbGeometryPkg::laneT startBank;

	btbReadIf readBus ();
	btbWriteIf writeBus ();

	// **************************************************
	// Lookup path.
	// **************************************************
	btbLaneAddr i_btbLaneAddr (
		.pc_i        (pc_i),
		.rd          (readBus.lane),
		.instTag_o   (instTag),
		.startBank_o (startBank)
	);

	// One bank per lane.
	for (genvar b = 0; b < btbGeometryPkg::FETCH_WIDTH; b++)
	begin : bankGen
		btbBank #(
			.BANK_ID (b)
		) i_btbBank (
			.clk   (clk),
			.rst_i (rst_i),
			.rd    (readBus.bank),
			.wr    (writeBus.sink)
		);
	end

	btbHitCheck i_btbHitCheck (
		.rd             (readBus.check),
		.instTag_i      (instTag),
		.startBank_i    (startBank),
		.laneHit_o      (laneHit_o),
		.laneTarget_o   (laneTarget_o),
		.laneCtrlType_o (laneCtrlType_o)
	);

	// **************************************************
	// Update path.
	// **************************************************
	btbUpdate i_btbUpdate (
		.updateEn_i       (updateEn_i),
		.updatePc_i       (updatePc_i),
		.updateTarget_i   (updateTarget_i),
		.updateCtrlType_i (updateCtrlType_i),
		.wr               (writeBus.source)
	);

endmodule

`default_nettype wire

// ==== btbTop_assert.sv ====
`timescale 1ns/10ps
`default_nettype none

// Protocol properties of the BTB top level.
module btbTopAssert (
	input logic clk,
	input logic rst_i,
	input btbGeometryPkg::pcT pc_i,
	input logic updateEn_i,
	input btbGeometryPkg::pcT updatePc_i,
	input btbEntryPkg::targetT updateTarget_i,
	input logic [btbGeometryPkg::FETCH_WIDTH-1:0] laneHit_o,
	input btbEntryPkg::targetT [btbGeometryPkg::FETCH_WIDTH-1:0] laneTarget_o
);

	// Failures seen so far, read by the testbench.
	int assertFails = 0;

	// Hits are always known once out of reset.
	hitKnown: assert property (@(posedge clk) disable iff (rst_i) !$isunknown(laneHit_o))
	else
	begin
		assertFails++;
		$error("lane hit vector is unknown");
	end

	// Reset empties every bank.
	resetClears: assert property (@(posedge clk) rst_i |=> (laneHit_o == '0))
	else
	begin
		assertFails++;
		$error("hit seen one cycle after reset");
	end

	// Fresh write is visible on lane 0 at the same PC.
	updateVisible: assert property (@(posedge clk)
		($past(updateEn_i) && !$past(rst_i) && (pc_i == $past(updatePc_i)))
		|-> (laneHit_o[0] && (laneTarget_o[0] == $past(updateTarget_i))))
	else
	begin
		assertFails++;
		$error("update not visible on lane 0");
	end

endmodule

bind btbTop btbTopAssert i_btbTopAssert (
	.clk            (clk),
	.rst_i          (rst_i),
	.pc_i           (pc_i),
	.updateEn_i     (updateEn_i),
	.updatePc_i     (updatePc_i),
	.updateTarget_i (updateTarget_i),
	.laneHit_o      (laneHit_o),
	.laneTarget_o   (laneTarget_o)
);

`default_nettype wire

// ==== btbTb.sv ====
`timescale 1ns/10ps
`default_nettype none

// Directed testbench for the banked BTB, checked against a reference model.
module btbTb;

	// Clock period and drive and sample offsets in ns.
	localparam int CLK_PERIOD = 8;
	localparam int DRIVE_DELAY = 1;
	localparam int SAMPLE_DELAY = 2;
	localparam int RESET_CYCLES = 3;
	localparam int RANDOM_UPDATES = 200;

	// Cycle budget of all tests.
	// The reset clear test resets twice.
	localparam int TEST_CYCLES = 7 * RESET_CYCLES
		+ 11    // Reset clear fill and lookups.
		+ 2     // Single hit.
		+ 8     // Rotation.
		+ 6     // Tag mismatch.
		+ 8     // Wraparound.
		+ 2 * RANDOM_UPDATES;

	// Instruction address is the PC without its byte offset.
	typedef logic [btbGeometryPkg::SIZE_PC-btbGeometryPkg::INST_BYTE_OFFSET-1:0] instAddrT;

	logic clk;
	logic rst;
	btbGeometryPkg::pcT pc;
	logic updateEn;
	btbGeometryPkg::pcT updatePc;
	btbEntryPkg::targetT updateTarget;
	btbEntryPkg::ctrlTypeT updateCtrlType;
	logic [btbGeometryPkg::FETCH_WIDTH-1:0] laneHit;
	btbEntryPkg::targetT [btbGeometryPkg::FETCH_WIDTH-1:0] laneTarget;
	btbEntryPkg::ctrlTypeT [btbGeometryPkg::FETCH_WIDTH-1:0] laneCtrlType;

	// Reference model indexed by bank * BANK_DEPTH + index.
	logic modelValid [btbGeometryPkg::BTB_SIZE];
	btbGeometryPkg::tagT modelTag [btbGeometryPkg::BTB_SIZE];
	btbEntryPkg::targetT modelTarget [btbGeometryPkg::BTB_SIZE];
	btbEntryPkg::ctrlTypeT modelCtrlType [btbGeometryPkg::BTB_SIZE];

	int checkCount;
	int errorCount;
	integer seed;

	btbTop i_btbTop (
		.clk              (clk),
		.rst_i            (rst),
		.pc_i             (pc),
		.updateEn_i       (updateEn),
		.updatePc_i       (updatePc),
		.updateTarget_i   (updateTarget),
		.updateCtrlType_i (updateCtrlType),
		.laneHit_o        (laneHit),
		.laneTarget_o     (laneTarget),
		.laneCtrlType_o   (laneCtrlType)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Watchdog at twice the expected run length.
	initial
	begin
		#(TEST_CYCLES * CLK_PERIOD * 2);
		$display("Watchdog expired before the tests finished");
		$display("Simulation failed");
		$finish;
	end

	// **************************************************
	// Address mapping and the reference model.
	// **************************************************
	// Instruction address of one lane that wraps like the PC.
	function automatic instAddrT slotAddr(input btbGeometryPkg::pcT pcVal, input int lane);
		slotAddr = instAddrT'(pcVal >> btbGeometryPkg::INST_BYTE_OFFSET) + instAddrT'(lane);
	endfunction

	// Bank is a mod 4 and index is (a / 4) mod 64.
	function automatic int modelSlot(input instAddrT a);
		modelSlot = (a % btbGeometryPkg::FETCH_WIDTH) * btbGeometryPkg::BANK_DEPTH
			+ (a / btbGeometryPkg::FETCH_WIDTH) % btbGeometryPkg::BANK_DEPTH;
	endfunction

	// Tag is a / 256 cut to the tag width.
	function automatic btbGeometryPkg::tagT slotTag(input instAddrT a);
		slotTag = btbGeometryPkg::tagT'(a / btbGeometryPkg::BTB_SIZE);
	endfunction

	// PC of a slot, given its instruction address.
	function automatic btbGeometryPkg::pcT slotPc(input int a);
		slotPc = btbGeometryPkg::pcT'(a) << btbGeometryPkg::INST_BYTE_OFFSET;
	endfunction

	// Narrow region with four tags to force aliasing.
	function automatic btbGeometryPkg::pcT randomPc();
		int a;
		a = (40 + ($random(seed) & 3)) * btbGeometryPkg::BTB_SIZE + ($random(seed) & 15);
		randomPc = slotPc(a) | btbGeometryPkg::pcT'($random(seed) & 7);
	endfunction

	// **************************************************
	// Compare tasks.
	// **************************************************
	task automatic checkHit(input string name, input int lane, input logic expHit,
		input logic actHit);
		checkCount++;
		if (actHit !== expHit)
		begin
			errorCount++;
			$display("mismatch %s lane %0d hit: expected %0b, actual %0b",
				name, lane, expHit, actHit);
		end
	endtask

	task automatic checkTarget(input string name, input int lane,
		input btbEntryPkg::targetT expTarget, input btbEntryPkg::targetT actTarget);
		checkCount++;
		if (actTarget !== expTarget)
		begin
			errorCount++;
			$display("mismatch %s lane %0d target: expected %h, actual %h",
				name, lane, expTarget, actTarget);
		end
	endtask

	task automatic checkCtrlType(input string name, input int lane,
		input btbEntryPkg::ctrlTypeT expType, input btbEntryPkg::ctrlTypeT actType);
		checkCount++;
		if (actType !== expType)
		begin
			errorCount++;
			$display("mismatch %s lane %0d control type: expected %0d, actual %0d",
				name, lane, expType, actType);
		end
	endtask

	// **************************************************
	// Drivers that return 1 ns after a rising edge.
	// **************************************************
	task automatic resetDut();
		rst = 1'b1;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst = 1'b0;
		for (int s = 0; s < btbGeometryPkg::BTB_SIZE; s++)
		begin
			modelValid[s] = 1'b0;
		end
	endtask

	// One update strobe and the matching model write.
	task automatic writeEntry(input btbGeometryPkg::pcT wrPc, input btbEntryPkg::targetT target,
		input btbEntryPkg::ctrlTypeT ctrlType);
		instAddrT a;
		int slot;
		updateEn = 1'b1;
		updatePc = wrPc;
		updateTarget = target;
		updateCtrlType = ctrlType;
		@(posedge clk);
		#DRIVE_DELAY;
		updateEn = 1'b0;
		a = slotAddr(wrPc, 0);
		slot = modelSlot(a);
		modelValid[slot] = 1'b1;
		modelTag[slot] = slotTag(a);
		modelTarget[slot] = target;
		modelCtrlType[slot] = ctrlType;
	endtask

	// Lookup is combinational and sampled mid-cycle.
	task automatic lookupAndCheck(input string name, input btbGeometryPkg::pcT lookPc);
		instAddrT a;
		int slot;
		logic expHit;
		pc = lookPc;
		#SAMPLE_DELAY;
		for (int lane = 0; lane < btbGeometryPkg::FETCH_WIDTH; lane++)
		begin
			a = slotAddr(lookPc, lane);
			slot = modelSlot(a);
			expHit = modelValid[slot] && (modelTag[slot] == slotTag(a));
			checkHit(name, lane, expHit, laneHit[lane]);
			// Payload only means something on a hit.
			if (expHit)
			begin
				checkTarget(name, lane, modelTarget[slot], laneTarget[lane]);
				checkCtrlType(name, lane, modelCtrlType[slot], laneCtrlType[lane]);
			end
		end
		@(posedge clk);
		#DRIVE_DELAY;
	endtask

	// **************************************************
	// Tests.
	// **************************************************
	task automatic resetClearLookups();
		btbGeometryPkg::pcT probePc [5];
		probePc = '{32'h0000_0000, 32'h0000_0808, 32'h1234_5678, 32'hffff_fff8,
			32'h8000_0004};
		resetDut();
		// Fill the probed slots so the reset has entries to clear.
		foreach (probePc[k])
		begin
			writeEntry(probePc[k], 32'h3000_0000 + 32'(k * 8), btbEntryPkg::ctrlTypeT'(k));
		end
		resetDut();
		foreach (probePc[k])
		begin
			lookupAndCheck("resetClear", probePc[k]);
		end
		lookupAndCheck("resetClear", randomPc());
	endtask

	task automatic singleEntryHit();
		resetDut();
		writeEntry(32'h0002_0040, 32'h0001_2340, 2'd1);
		lookupAndCheck("singleHit", 32'h0002_0040);
	endtask

	// Four slots at tag 2 and index 20 looked up from every offset.
	task automatic rotatedLookups();
		int base;
		base = 2 * btbGeometryPkg::BTB_SIZE + 20 * btbGeometryPkg::FETCH_WIDTH;
		resetDut();
		for (int k = 0; k < btbGeometryPkg::FETCH_WIDTH; k++)
		begin
			writeEntry(slotPc(base + k), 32'h1000_0000 + 32'(k * 16), btbEntryPkg::ctrlTypeT'(k));
		end
		for (int s = 0; s < btbGeometryPkg::FETCH_WIDTH; s++)
		begin
			lookupAndCheck("rotation", slotPc(base + s));
		end
	endtask

	// Same bank and index with tags 3 and 9.
	task automatic tagReplacement();
		btbGeometryPkg::pcT pcA;
		btbGeometryPkg::pcT pcB;
		pcA = slotPc(3 * btbGeometryPkg::BTB_SIZE + 41);
		pcB = slotPc(9 * btbGeometryPkg::BTB_SIZE + 41);
		resetDut();
		writeEntry(pcA, 32'h0000_a000, 2'd2);
		lookupAndCheck("tagMismatch", pcA);
		lookupAndCheck("tagMismatch", pcB);
		writeEntry(pcB, 32'h0000_b000, 2'd3);
		lookupAndCheck("tagMismatch", pcB);
		lookupAndCheck("tagMismatch", pcA);
	endtask

	// Block from index 63 of tag 5 into index 0 of tag 6.
	task automatic indexWraparound();
		int base;
		base = 5 * btbGeometryPkg::BTB_SIZE + 254;
		resetDut();
		for (int k = 0; k < btbGeometryPkg::FETCH_WIDTH; k++)
		begin
			writeEntry(slotPc(base + k), 32'h2000_0000 + 32'(k * 4), btbEntryPkg::ctrlTypeT'(3 - k));
		end
		lookupAndCheck("wraparound", slotPc(base));
		lookupAndCheck("wraparound", slotPc(base - 2));
		lookupAndCheck("wraparound", slotPc(base + 2));
		// Bank 0 index 0 holds tag 6 so tag 5 misses there.
		lookupAndCheck("wraparound", slotPc(5 * btbGeometryPkg::BTB_SIZE));
	endtask

	task automatic randomTraffic();
		resetDut();
		for (int n = 0; n < RANDOM_UPDATES; n++)
		begin
			writeEntry(randomPc(), btbEntryPkg::targetT'($random(seed)),
				btbEntryPkg::ctrlTypeT'($random(seed)));
			lookupAndCheck("random", randomPc());
		end
	endtask

	// **************************************************
	// Main sequence.
	// **************************************************
	initial
	begin
		seed = 32'h70b09f66;
		checkCount = 0;
		errorCount = 0;
		rst = 1'b1;
		pc = '0;
		updateEn = 1'b0;
		updatePc = '0;
		updateTarget = '0;
		updateCtrlType = '0;

		resetClearLookups();
		singleEntryHit();
		rotatedLookups();
		tagReplacement();
		indexWraparound();
		randomTraffic();

		$display("Checks %0d, errors %0d, assertion failures %0d",
			checkCount, errorCount, i_btbTop.i_btbTopAssert.assertFails);
		if (errorCount == 0 && i_btbTop.i_btbTopAssert.assertFails == 0)
		begin
			$display("Simulation passed");
		end
		else
		begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== sim.f ====
btbGeometryPkg.sv
btbEntryPkg.sv
btbIf.sv
btbLaneAddr.sv
btbBank.sv
btbUpdate.sv
btbHitCheck.sv
btbTop.sv
btbTop_assert.sv
btbTb.sv

// ==== Bender.yml ====
package:
  name: btb

sources:
  # Packages first, then interfaces and RTL.
  - btbGeometryPkg.sv
  - btbEntryPkg.sv
  - btbIf.sv
  - btbLaneAddr.sv
  - btbBank.sv
  - btbUpdate.sv
  - btbHitCheck.sv
  - btbTop.sv

  # Testbench sources.
  - target: test
    files:
      - btbTop_assert.sv
      - btbTb.sv
